/* common/emesh_pkg.sv */
`default_nettype none

package emesh_pkg;

  // ############################
  // Mesh packet format
  // ############################

  // Source word, meaning depends on the transaction type
  typedef union packed {
    // Return address of a read
    logic [31:0] srcaddr;
    // Upper data word of a double-data write
    logic [31:0] hi_data;
  } emesh_src_t;

  // One mesh transaction, 104 bits wide
  // Field order matches the wire layout, msb first
  typedef struct packed {
    // Unused, kept for layout
    logic       spare;
    // Set for writes and read responses
    logic       write;
    // Access size
    logic [1:0] datamode;
    // Transaction modifiers
    logic [3:0] ctrlmode;
    // Target address
    // Bits 31:20 select the link
    // Bits 19:16 select the group inside it
    logic [31:0] dstaddr;
    // Payload, lower word
    logic [31:0] data;
    // Return address or upper payload word
    emesh_src_t src;
  } emesh_packet_t;

endpackage

`default_nettype wire

/* common/erx_map_pkg.sv */
`default_nettype none

package erx_map_pkg;

  // ############################
  // Link address map
  // ############################

  // Width of a link ID, dstaddr bits 31:20
  localparam int ID_W = 12;

  // Group codes, dstaddr bits 19:16
  // Read response returning to this link
  localparam logic [3:0] EGROUP_RR  = 4'hE;
  // Write into the translation table
  localparam logic [3:0] EGROUP_MMU = 4'hF;

  // ############################
  // MMU table geometry
  // ############################

  // One entry per value of dstaddr bits 31:28
  localparam int MMU_ENTRIES = 16;
  localparam int MMU_IDX_W   = 4;

endpackage

`default_nettype wire

/* common/emesh_if.sv */
`default_nettype none

// Stage link between the MMU and the distributor
// Transfer happens on a clock edge with access high and wait_req low
interface emesh_if;
  import emesh_pkg::*;

  // Packet present
  logic          access;
  emesh_packet_t packet;
  // Packet addressed to this link's own ID
  logic          is_local;
  // Receiver stall, sender holds everything while high
  logic          wait_req;

  modport sender (
    output access,
    output packet,
    output is_local,
    input  wait_req
  );

  modport receiver (
    input  access,
    input  packet,
    input  is_local,
    output wait_req
  );

endinterface

`default_nettype wire

/* hw/erx_mmu.sv */
`default_nettype none

module erx_mmu #(
  parameter logic [erx_map_pkg::ID_W-1:0] ID = 12'h800
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     erx_access,
  input  emesh_pkg::emesh_packet_t erx_packet,
  output logic                     erx_wait,
  emesh_if.sender                  out
);
  import emesh_pkg::*;
  import erx_map_pkg::*;

  // Translation table, one link ID per entry
  logic [ID_W-1:0]      mmu_table [MMU_ENTRIES];

  logic                 in_local;
  logic                 tbl_write;
  logic                 accept;
  logic [MMU_IDX_W-1:0] tbl_idx;
  logic [MMU_IDX_W-1:0] wr_idx;
  emesh_packet_t        xlat_packet;

  // Output stage
  logic                 out_access;
  logic                 out_local;
  emesh_packet_t        out_packet;

  // ############################
  // Decode
  // ############################

  assign in_local  = (erx_packet.dstaddr[31:20] == ID);
  // Table programming, consumed here
  assign tbl_write = in_local & erx_packet.write &
                     (erx_packet.dstaddr[19:16] == EGROUP_MMU);
  // Lookup by top nibble of the address
  assign tbl_idx   = erx_packet.dstaddr[31:28];
  // Entry select for a table write, word addressed
  assign wr_idx    = erx_packet.dstaddr[5:2];

  // Stall only while holding a packet the distributor refuses
  assign erx_wait  = out_access & out.wait_req;
  assign accept    = erx_access & ~erx_wait;

  // ############################
  // Translation
  // ############################

  always_comb begin
    xlat_packet = erx_packet;
    // Local packets keep their address
    if (!in_local) begin
      xlat_packet.dstaddr[31:20] = mmu_table[tbl_idx];
    end
  end

  // Identity-like default, entry i points at link {i, 8'h00}
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < MMU_ENTRIES; i++) begin
        mmu_table[i] <= {MMU_IDX_W'(i), 8'h00};
      end
    end else if (accept && tbl_write) begin
      mmu_table[wr_idx] <= erx_packet.data[ID_W-1:0];
    end
  end

  // ############################
  // Output register
  // ############################

  // Loads whenever not stalled, table writes leave it empty
  always_ff @(posedge clk) begin
    if (reset) begin
      out_access <= 1'b0;
      out_local  <= 1'b0;
    end else if (!erx_wait) begin
      out_access <= erx_access & ~tbl_write;
      out_local  <= in_local;
    end
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (!erx_wait) begin
      out_packet <= xlat_packet;
    end
  end

  assign out.access   = out_access;
  assign out.packet   = out_packet;
  assign out.is_local = out_local;

endmodule

`default_nettype wire

/* hw/erx_arbiter.sv */
`default_nettype none

module erx_arbiter (
  emesh_if.receiver                mmu,
  input  logic                     edma_access,
  input  emesh_pkg::emesh_packet_t edma_packet,
  output logic                     edma_wait,
  input  logic                     ecfg_access,
  input  emesh_pkg::emesh_packet_t ecfg_packet,
  output logic                     ecfg_wait,
  output logic                     rxwr_access,
  output emesh_pkg::emesh_packet_t rxwr_packet,
  input  logic                     rxwr_wait,
  output logic                     rxrd_access,
  output emesh_pkg::emesh_packet_t rxrd_packet,
  input  logic                     rxrd_wait,
  output logic                     rxrr_access,
  output emesh_pkg::emesh_packet_t rxrr_packet,
  input  logic                     rxrr_wait
);
  import erx_map_pkg::*;

  logic mmu_rr;
  logic mmu_rd;
  logic mmu_wr;

  // ############################
  // Steering
  // ############################

  // Read response coming back to this link
  assign mmu_rr = mmu.access & mmu.is_local & mmu.packet.write &
                  (mmu.packet.dstaddr[19:16] == EGROUP_RR);
  // Any read, local or translated
  assign mmu_rd = mmu.access & ~mmu.packet.write;
  // Remaining writes, including other local groups
  assign mmu_wr = mmu.access & mmu.packet.write & ~mmu_rr;

  // ############################
  // Queue inputs
  // ############################

  // Write queue, link traffic only
  assign rxwr_access = mmu_wr;
  assign rxwr_packet = mmu.packet;

  // Read queue, link reads win over DMA
  assign rxrd_access = mmu_rd | edma_access;
  assign rxrd_packet = mmu_rd ? mmu.packet : edma_packet;

  // Response queue, link responses win over config
  assign rxrr_access = mmu_rr | ecfg_access;
  assign rxrr_packet = mmu_rr ? mmu.packet : ecfg_packet;

  // ############################
  // Waits
  // ############################

  // Losing sources also stall when their queue is full
  assign edma_wait = mmu_rd | rxrd_wait;
  assign ecfg_wait = mmu_rr | rxrr_wait;

  // MMU sees only the queue its packet targets
  assign mmu.wait_req = (mmu_rr & rxrr_wait) |
                        (mmu_rd & rxrd_wait) |
                        (mmu_wr & rxwr_wait);

endmodule

`default_nettype wire

/* hw/erx_fifo.sv */
`default_nettype none

module erx_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_access,
  input  emesh_pkg::emesh_packet_t in_packet,
  output logic                     in_wait,
  output logic                     out_access,
  output emesh_pkg::emesh_packet_t out_packet,
  input  logic                     out_wait
);
  import emesh_pkg::*;

  // Pointer and count widths, depth is a power of two
  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int CW = AW + 1;

  emesh_packet_t mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  // Full blocks the writer, nonempty presents the head
  assign in_wait    = (count == CW'(FIFO_DEPTH));
  assign out_access = (count != '0);
  assign out_packet = mem[rd_ptr];

  assign push = in_access & ~in_wait;
  assign pop  = out_access & ~out_wait;

  // Storage, no reset
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_packet;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/erx_core.sv */
`default_nettype none

module erx_core #(
  parameter logic [erx_map_pkg::ID_W-1:0] ID         = 12'h800,
  parameter int                           FIFO_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  // From link I/O
  input  logic                     erx_access,
  input  emesh_pkg::emesh_packet_t erx_packet,
  output logic                     erx_wait,
  // DMA read source
  input  logic                     edma_access,
  input  emesh_pkg::emesh_packet_t edma_packet,
  output logic                     edma_wait,
  // Config read responses
  input  logic                     ecfg_access,
  input  emesh_pkg::emesh_packet_t ecfg_packet,
  output logic                     ecfg_wait,
  // Master write queue
  output logic                     wr_access,
  output emesh_pkg::emesh_packet_t wr_packet,
  input  logic                     wr_wait,
  // Master read queue
  output logic                     rd_access,
  output emesh_pkg::emesh_packet_t rd_packet,
  input  logic                     rd_wait,
  // Slave read-response queue
  output logic                     rr_access,
  output emesh_pkg::emesh_packet_t rr_packet,
  input  logic                     rr_wait
);
  import emesh_pkg::*;

  // Distributor to queue links
  logic          rxwr_access;
  emesh_packet_t rxwr_packet;
  logic          rxwr_wait;
  logic          rxrd_access;
  emesh_packet_t rxrd_packet;
  logic          rxrd_wait;
  logic          rxrr_access;
  emesh_packet_t rxrr_packet;
  logic          rxrr_wait;

  // MMU to distributor
  emesh_if mmu_link ();

  // ############################
  // Translation stage
  // ############################

  erx_mmu #(
    .ID (ID)
  ) u_mmu (
    .clk        (clk),
    .reset      (reset),
    .erx_access (erx_access),
    .erx_packet (erx_packet),
    .erx_wait   (erx_wait),
    .out        (mmu_link.sender)
  );

  // ############################
  // Distributor
  // ############################

  erx_arbiter u_arbiter (
    .mmu         (mmu_link.receiver),
    .edma_access (edma_access),
    .edma_packet (edma_packet),
    .edma_wait   (edma_wait),
    .ecfg_access (ecfg_access),
    .ecfg_packet (ecfg_packet),
    .ecfg_wait   (ecfg_wait),
    .rxwr_access (rxwr_access),
    .rxwr_packet (rxwr_packet),
    .rxwr_wait   (rxwr_wait),
    .rxrd_access (rxrd_access),
    .rxrd_packet (rxrd_packet),
    .rxrd_wait   (rxrd_wait),
    .rxrr_access (rxrr_access),
    .rxrr_packet (rxrr_packet),
    .rxrr_wait   (rxrr_wait)
  );

  // ############################
  // Output queues
  // ############################

  erx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_wr_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_access  (rxwr_access),
    .in_packet  (rxwr_packet),
    .in_wait    (rxwr_wait),
    .out_access (wr_access),
    .out_packet (wr_packet),
    .out_wait   (wr_wait)
  );

  erx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rd_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_access  (rxrd_access),
    .in_packet  (rxrd_packet),
    .in_wait    (rxrd_wait),
    .out_access (rd_access),
    .out_packet (rd_packet),
    .out_wait   (rd_wait)
  );

  erx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rr_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_access  (rxrr_access),
    .in_packet  (rxrr_packet),
    .in_wait    (rxrr_wait),
    .out_access (rr_access),
    .out_packet (rr_packet),
    .out_wait   (rr_wait)
  );

endmodule

`default_nettype wire

/* tb/erx_core_checker.sv */
`default_nettype none

// Handshake checks, bound into the queues and the top level
module erx_core_checker (
  input logic                     clk,
  input logic                     reset,
  // Handshake under watch
  input logic                     access,
  input emesh_pkg::emesh_packet_t packet,
  input logic                     stall,
  // Condition that must force the input stall
  input logic                     full,
  input logic                     in_wait
);
  timeunit 1ns;
  timeprecision 100ps;

  // Stalled sender keeps its packet
  property hold_while_stalled;
    @(posedge clk) disable iff (reset)
      access && stall |=> access && $stable(packet);
  endproperty

  // No acceptance while full
  property stall_when_full;
    @(posedge clk) disable iff (reset)
      full |-> in_wait;
  endproperty

  hold_check: assert property (hold_while_stalled)
    else $error("packet or access changed while stalled");

  full_check: assert property (stall_when_full)
    else $error("input wait low while full");

endmodule

// Queue read side held under wait
// Pointers meet with data inside only when every slot is taken
bind erx_fifo erx_core_checker u_fifo_chk (
  .clk     (clk),
  .reset   (reset),
  .access  (out_access),
  .packet  (out_packet),
  .stall   (out_wait),
  .full    ((wr_ptr == rd_ptr) && (count != '0)),
  .in_wait (in_wait)
);

// MMU register held while the distributor refuses it
// Refused means the queue the packet targets is waiting
bind erx_core erx_core_checker u_core_chk (
  .clk     (clk),
  .reset   (reset),
  .access  (mmu_link.access),
  .packet  (mmu_link.packet),
  .stall   (mmu_link.wait_req),
  .full    (mmu_link.access &
            (mmu_link.packet.write ?
             ((mmu_link.is_local &&
               mmu_link.packet.dstaddr[19:16] == erx_map_pkg::EGROUP_RR) ?
              rxrr_wait : rxwr_wait) :
             rxrd_wait)),
  .in_wait (erx_wait)
);

`default_nettype wire

/* tb/erx_core_tb.sv */
`default_nettype none

module erx_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import emesh_pkg::*;
  import erx_map_pkg::*;

  localparam logic [ID_W-1:0] LINK_ID = 12'h800;
  localparam int TIMEOUT = 200;

  // Destination queues
  localparam int Q_NONE = 0;
  localparam int Q_WR   = 1;
  localparam int Q_RD   = 2;
  localparam int Q_RR   = 3;

  // Packet sources
  localparam int SRC_ERX = 0;
  localparam int SRC_DMA = 1;
  localparam int SRC_CFG = 2;

  logic          clk;
  logic          reset;
  logic          erx_access;
  emesh_packet_t erx_packet;
  logic          erx_wait;
  logic          edma_access;
  emesh_packet_t edma_packet;
  logic          edma_wait;
  logic          ecfg_access;
  emesh_packet_t ecfg_packet;
  logic          ecfg_wait;
  logic          wr_access;
  emesh_packet_t wr_packet;
  logic          wr_wait;
  logic          rd_access;
  emesh_packet_t rd_packet;
  logic          rd_wait;
  logic          rr_access;
  emesh_packet_t rr_packet;
  logic          rr_wait;

  // Model of the translation table
  logic [ID_W-1:0] model_table [MMU_ENTRIES];
  // Expected packets per queue, in order
  emesh_packet_t   exp_wr [$];
  emesh_packet_t   exp_rd [$];
  emesh_packet_t   exp_rr [$];

  int     mismatches;
  int     other_errors;
  integer seed;
  logic   stall_random;
  string  test_name;

  erx_core #(
    .ID         (LINK_ID),
    .FIFO_DEPTH (4)
  ) uut (
    .clk         (clk),
    .reset       (reset),
    .erx_access  (erx_access),
    .erx_packet  (erx_packet),
    .erx_wait    (erx_wait),
    .edma_access (edma_access),
    .edma_packet (edma_packet),
    .edma_wait   (edma_wait),
    .ecfg_access (ecfg_access),
    .ecfg_packet (ecfg_packet),
    .ecfg_wait   (ecfg_wait),
    .wr_access   (wr_access),
    .wr_packet   (wr_packet),
    .wr_wait     (wr_wait),
    .rd_access   (rd_access),
    .rd_packet   (rd_packet),
    .rd_wait     (rd_wait),
    .rr_access   (rr_access),
    .rr_packet   (rr_packet),
    .rr_wait     (rr_wait)
  );

  always #2 clk = ~clk;

  // ############################
  // Reference model
  // ############################

  // Destination queue and the packet as it should leave
  function automatic int predict_packet(input emesh_packet_t pkt,
                                        output emesh_packet_t exp_pkt);
    logic is_local;
    is_local = (pkt.dstaddr[31:20] == LINK_ID);
    exp_pkt  = pkt;
    if (!is_local) begin
      exp_pkt.dstaddr[31:20] = model_table[pkt.dstaddr[31:28]];
    end
    if (is_local && pkt.write && pkt.dstaddr[19:16] == EGROUP_MMU) begin
      return Q_NONE;
    end
    if (is_local && pkt.write && pkt.dstaddr[19:16] == EGROUP_RR) begin
      return Q_RR;
    end
    if (!pkt.write) begin
      return Q_RD;
    end
    return Q_WR;
  endfunction

  // Src word read as return address or upper data
  function automatic emesh_packet_t build_packet(input logic write,
                                                 input logic [31:0] dstaddr,
                                                 input logic [31:0] data);
    emesh_packet_t p;
    p          = '0;
    p.write    = write;
    p.datamode = 2'b10;
    p.dstaddr  = dstaddr;
    p.data     = data;
    if (write) begin
      p.src.hi_data = data ^ 32'h5a5a_5a5a;
    end else begin
      p.src.srcaddr = {LINK_ID, 20'h0_0100};
    end
    return p;
  endfunction

  function automatic logic source_wait(input int src);
    case (src)
      SRC_ERX: return erx_wait;
      SRC_DMA: return edma_wait;
      default: return ecfg_wait;
    endcase
  endfunction

  // ############################
  // Stimulus helpers
  // ############################

  task automatic drive_source(input int src, input logic access, input emesh_packet_t pkt);
    case (src)
      SRC_ERX: begin
        erx_access = access;
        erx_packet = pkt;
      end
      SRC_DMA: begin
        edma_access = access;
        edma_packet = pkt;
      end
      default: begin
        ecfg_access = access;
        ecfg_packet = pkt;
      end
    endcase
  endtask

  // Called just after a rising edge, returns just after the accepting edge
  task automatic send_packet(input int src, input emesh_packet_t pkt, output logic stalled);
    emesh_packet_t exp_pkt;
    int            dest;
    int            cycles;
    logic          busy;
    if (src == SRC_ERX) begin
      dest = predict_packet(pkt, exp_pkt);
    end else begin
      exp_pkt = pkt;
      dest    = (src == SRC_DMA) ? Q_RD : Q_RR;
    end
    drive_source(src, 1'b1, pkt);
    stalled = 1'b0;
    cycles  = 0;
    @(negedge clk);
    busy = source_wait(src);
    while (busy && cycles < TIMEOUT) begin
      stalled = 1'b1;
      cycles++;
      @(negedge clk);
      busy = source_wait(src);
    end
    if (busy) begin
      $display("Timeout: source %0d never accepted a packet in %s", src, test_name);
      other_errors++;
    end else begin
      // Accepted on the coming edge
      case (dest)
        Q_NONE: model_table[pkt.dstaddr[5:2]] = pkt.data[ID_W-1:0];
        Q_WR:   exp_wr.push_back(exp_pkt);
        Q_RD:   exp_rd.push_back(exp_pkt);
        default: exp_rr.push_back(exp_pkt);
      endcase
    end
    @(posedge clk);
    #0.5;
    drive_source(src, 1'b0, pkt);
  endtask

  // Wait until every expected packet has left
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_wr.size() + exp_rd.size() + exp_rr.size()) != 0 && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if ((exp_wr.size() + exp_rd.size() + exp_rr.size()) != 0) begin
      $display("Timeout: %0d expected packets never appeared in %s",
               exp_wr.size() + exp_rd.size() + exp_rr.size(), test_name);
      other_errors++;
      exp_wr.delete();
      exp_rd.delete();
      exp_rr.delete();
    end
    @(posedge clk);
    #0.5;
  endtask

  task automatic check_packet(input string queue_name, input emesh_packet_t expected,
                              input emesh_packet_t actual);
    if (actual !== expected) begin
      $display("Mismatch in %s on %s: expected %h, actual %h",
               test_name, queue_name, expected, actual);
      mismatches++;
    end
  endtask

  // ############################
  // Output comparison
  // ############################

  // Sampled mid-cycle, transfer happens on the next rising edge
  always @(negedge clk) begin
    if (!reset) begin
      if (wr_access && !wr_wait) begin
        if (exp_wr.size() == 0) begin
          $display("Unexpected packet %h on wr in %s", wr_packet, test_name);
          other_errors++;
        end else begin
          check_packet("wr", exp_wr.pop_front(), wr_packet);
        end
      end
      if (rd_access && !rd_wait) begin
        if (exp_rd.size() == 0) begin
          $display("Unexpected packet %h on rd in %s", rd_packet, test_name);
          other_errors++;
        end else begin
          check_packet("rd", exp_rd.pop_front(), rd_packet);
        end
      end
      if (rr_access && !rr_wait) begin
        if (exp_rr.size() == 0) begin
          $display("Unexpected packet %h on rr in %s", rr_packet, test_name);
          other_errors++;
        end else begin
          check_packet("rr", exp_rr.pop_front(), rr_packet);
        end
      end
    end
  end

  // Consumer back-pressure
  always @(posedge clk) begin
    #0.5;
    if (stall_random) begin
      wr_wait = ($random(seed) & 1) != 0;
      rd_wait = ($random(seed) & 1) != 0;
      rr_wait = ($random(seed) & 1) != 0;
    end else begin
      wr_wait = 1'b0;
      rd_wait = 1'b0;
      rr_wait = 1'b0;
    end
  end

  // ############################
  // Test sequence
  // ############################

  initial begin
    emesh_packet_t pkt;
    logic          stalled;
    logic [31:0]   addr;
    logic [31:0]   data;
    int            kind;
    clk          = 1'b0;
    reset        = 1'b1;
    seed         = 32'h57ce_61c3;
    stall_random = 1'b0;
    mismatches   = 0;
    other_errors = 0;
    test_name    = "reset";
    drive_source(SRC_ERX, 1'b0, '0);
    drive_source(SRC_DMA, 1'b0, '0);
    drive_source(SRC_CFG, 1'b0, '0);
    wr_wait = 1'b0;
    rd_wait = 1'b0;
    rr_wait = 1'b0;
    // Entry i points at {i, 8'h00} out of reset
    for (int i = 0; i < MMU_ENTRIES; i++) begin
      model_table[i] = {i[3:0], 8'h00};
    end
    repeat (8) @(posedge clk);
    #0.5;
    reset = 1'b0;
    @(negedge clk);
    if (wr_access || rd_access || rr_access || erx_wait || edma_wait || ecfg_wait) begin
      $display("Outputs not idle after reset");
      other_errors++;
    end
    @(posedge clk);
    #0.5;

    test_name = "nonlocal_write";
    send_packet(SRC_ERX, build_packet(1'b1, 32'h3ab0_0010, 32'h1111_2222), stalled);
    send_packet(SRC_ERX, build_packet(1'b1, 32'hc123_4564, 32'h3333_4444), stalled);
    wait_drain();

    test_name = "table_write";
    // Entry 5 now points at link 12'habc
    send_packet(SRC_ERX, build_packet(1'b1, {LINK_ID, EGROUP_MMU, 16'h0014},
                                      32'h0000_0abc), stalled);
    repeat (3) begin
      @(negedge clk);
      if (wr_access || rd_access || rr_access) begin
        $display("Table write produced an output packet");
        other_errors++;
      end
    end
    @(posedge clk);
    #0.5;
    send_packet(SRC_ERX, build_packet(1'b1, 32'h5123_4560, 32'h5555_6666), stalled);
    wait_drain();

    test_name = "read_merge";
    send_packet(SRC_DMA, build_packet(1'b0, 32'h2000_0040, 32'h0), stalled);
    wait_drain();
    // DMA arrives while the link read sits in the MMU register
    send_packet(SRC_ERX, build_packet(1'b0, 32'h7010_0080, 32'h0), stalled);
    send_packet(SRC_DMA, build_packet(1'b0, 32'h2000_0044, 32'h0), stalled);
    if (!stalled) begin
      $display("edma_wait stayed low while a link read was pending");
      other_errors++;
    end
    wait_drain();

    test_name = "read_response";
    send_packet(SRC_ERX, build_packet(1'b1, {LINK_ID, EGROUP_RR, 16'h0040},
                                      32'hfeed_0001), stalled);
    send_packet(SRC_CFG, build_packet(1'b1, 32'h9000_0100, 32'hc0f9_0002), stalled);
    if (!stalled) begin
      $display("ecfg_wait stayed low while a link response was pending");
      other_errors++;
    end
    wait_drain();

    test_name = "random_backpressure";
    stall_random = 1'b1;
    for (int n = 0; n < 150; n++) begin
      kind = $random(seed) & 3;
      addr = $random(seed);
      data = $random(seed);
      case (kind)
        0: begin
          // Keep it off this link
          if (addr[31:20] == LINK_ID) begin
            addr[31] = ~addr[31];
          end
          pkt = build_packet(1'b1, addr, data);
        end
        1: pkt = build_packet(1'b0, addr, data);
        2: pkt = build_packet(1'b1, {LINK_ID, EGROUP_RR, addr[15:0]}, data);
        default: pkt = build_packet(1'b1, {LINK_ID, 4'h0, addr[15:0]}, data);
      endcase
      send_packet(SRC_ERX, pkt, stalled);
    end
    wait_drain();
    stall_random = 1'b0;
    repeat (4) @(posedge clk);

    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* erx_core.f */
common/emesh_pkg.sv
common/erx_map_pkg.sv
common/emesh_if.sv
hw/erx_mmu.sv
hw/erx_arbiter.sv
hw/erx_fifo.sv
hw/erx_core.sv
tb/erx_core_checker.sv
tb/erx_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the erx_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  -f erx_core.f --top-module erx_core_tb -o erx_core_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

output=$(./obj_dir/erx_core_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1
